// ==== design/spi_wb_pkg.sv ====
package spi_wb_pkg;

  typedef logic [31:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  wb_sel_t;
  typedef logic [7:0]  spi_cmd_t;
  typedef logic [1:0]  reg_off_t;  // word offset inside sys_block.

  // slave window table.
  localparam int n_slaves_c    = 1;
  localparam int sysblock_id_c = 0;

  localparam wb_addr_t slave_base_c [n_slaves_c] = '{32'h0000_0000};
  localparam wb_addr_t slave_high_c [n_slaves_c] = '{32'h0000_FFFF};

  localparam wb_data_t bus_err_word_c = 32'hBAD0_E770;

  // board identity.
  localparam wb_data_t    board_id_c = 32'd12;
  localparam logic [15:0] rev_maj_c  = 16'd1;
  localparam logic [15:0] rev_min_c  = 16'd0;
  localparam wb_data_t    rev_rcs_c  = 32'd0;

  localparam reg_off_t reg_id_c      = 2'd0;
  localparam reg_off_t reg_rev_c     = 2'd1;
  localparam reg_off_t reg_rcs_c     = 2'd2;
  localparam reg_off_t reg_scratch_c = 2'd3;

  typedef enum logic [2:0] {
    st_idle,   // wait for cs_n low.
    st_cmd,
    st_addr,
    st_data,   // write data or read dummy byte.
    st_bus,
    st_out,
    st_done    // hold until cs_n rises.
  } spi_state_t;

endpackage

// ==== design/wb_bus_if.sv ====
`timescale 1ns/1ps

interface wb_bus_if;

  logic                  cyc;
  logic                  stb;
  logic                  we;
  spi_wb_pkg::wb_sel_t   sel;
  spi_wb_pkg::wb_addr_t  adr;
  spi_wb_pkg::wb_data_t  dat_w;
  spi_wb_pkg::wb_data_t  dat_r;
  logic                  ack;
  logic                  err;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

// ==== design/spi_wb_bridge.sv ====
`timescale 1ns/1ps

module spi_wb_bridge (
  input  logic     sys_clk,
  input  logic     rst_n_i,
  input  logic     cs_n_i,
  input  logic     sclk_i,
  input  logic     mosi_i,
  output logic     miso_o,
  output logic     cmd_done_o,
  wb_bus_if.master wb
);

  logic [1:0] sclk_q;
  logic [1:0] cs_n_q;
  logic [1:0] mosi_q;
  logic       sclk_d;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_n_s;

  spi_wb_pkg::spi_state_t state;
  logic [4:0]             bit_cnt;
  logic                   wr_q;
  spi_wb_pkg::wb_data_t   shift_q;
  spi_wb_pkg::wb_data_t   shift_nxt;
  spi_wb_pkg::wb_data_t   out_q;
  spi_wb_pkg::spi_cmd_t   cmd_w;

  always_ff @(posedge sys_clk) begin
    if (!rst_n_i) begin
      sclk_q <= 2'b00;
      sclk_d <= 1'b0;
      cs_n_q <= 2'b11;  // deselected.
    end else begin
      sclk_q <= {sclk_q[0], sclk_i};
      sclk_d <= sclk_q[1];
      cs_n_q <= {cs_n_q[0], cs_n_i};
    end
  end

  always_ff @(posedge sys_clk) begin
    mosi_q <= {mosi_q[0], mosi_i};
  end

  assign sclk_rise = sclk_q[1] & ~sclk_d;
  assign sclk_fall = ~sclk_q[1] & sclk_d;
  assign cs_n_s    = cs_n_q[1];
  assign shift_nxt = {shift_q[30:0], mosi_q[1]};
  assign cmd_w     = shift_nxt[7:0];

  assign wb.sel = 4'hF;  // always full word.
  assign wb.we  = wr_q;

  // frame sequencing and bus control.
  always_ff @(posedge sys_clk) begin
    if (!rst_n_i) begin
      state      <= spi_wb_pkg::st_idle;
      bit_cnt    <= '0;
      wb.cyc     <= 1'b0;
      wb.stb     <= 1'b0;
      miso_o     <= 1'b0;
      cmd_done_o <= 1'b0;
    end else begin
      cmd_done_o <= 1'b0;
      if (sclk_rise) bit_cnt <= bit_cnt + 5'd1;
      case (state)
        spi_wb_pkg::st_idle: begin
          miso_o  <= 1'b0;
          bit_cnt <= '0;
          if (!cs_n_s) state <= spi_wb_pkg::st_cmd;
        end
        spi_wb_pkg::st_cmd: begin
          if (sclk_rise && bit_cnt == 5'd7) begin
            bit_cnt <= '0;
            state   <= spi_wb_pkg::st_addr;
          end
        end
        spi_wb_pkg::st_addr: begin
          if (sclk_rise && bit_cnt == 5'd31) begin
            bit_cnt <= '0;
            if (wr_q) begin
              state <= spi_wb_pkg::st_data;
            end else begin
              wb.cyc <= 1'b1;  // read runs during the dummy byte.
              wb.stb <= 1'b1;
              state  <= spi_wb_pkg::st_bus;
            end
          end
        end
        spi_wb_pkg::st_data: begin
          if (sclk_rise && wr_q && bit_cnt == 5'd31) begin
            wb.cyc <= 1'b1;
            wb.stb <= 1'b1;
            state  <= spi_wb_pkg::st_bus;
          end else if (sclk_rise && !wr_q && bit_cnt == 5'd7) begin
            bit_cnt <= '0;
            state   <= spi_wb_pkg::st_out;
          end
        end
        spi_wb_pkg::st_bus: begin
          if (wb.ack || wb.err) begin
            wb.cyc     <= 1'b0;
            wb.stb     <= 1'b0;
            cmd_done_o <= 1'b1;
            state      <= wr_q ? spi_wb_pkg::st_done : spi_wb_pkg::st_data;
          end
        end
        spi_wb_pkg::st_out: begin
          if (sclk_fall) miso_o <= out_q[31];
          if (sclk_rise && bit_cnt == 5'd31) state <= spi_wb_pkg::st_done;
        end
        spi_wb_pkg::st_done: begin
        end
        default: state <= spi_wb_pkg::st_idle;
      endcase
      // an open bus access always finishes first.
      if (cs_n_s && state != spi_wb_pkg::st_bus) state <= spi_wb_pkg::st_idle;
    end
  end

  // shift registers and request fields.
  always_ff @(posedge sys_clk) begin
    if (sclk_rise) shift_q <= shift_nxt;
    if (sclk_rise && state == spi_wb_pkg::st_cmd && bit_cnt == 5'd7)
      wr_q <= cmd_w[7];
    if (sclk_rise && state == spi_wb_pkg::st_addr && bit_cnt == 5'd31)
      wb.adr <= shift_nxt;
    if (sclk_rise && state == spi_wb_pkg::st_data && wr_q && bit_cnt == 5'd31)
      wb.dat_w <= shift_nxt;
    if (state == spi_wb_pkg::st_bus && !wr_q && (wb.ack || wb.err))
      out_q <= wb.err ? spi_wb_pkg::bus_err_word_c : wb.dat_r;
    else if (state == spi_wb_pkg::st_out && sclk_fall)
      out_q <= {out_q[30:0], 1'b0};  // msb first.
  end

endmodule

// ==== design/wb_decoder.sv ====
`timescale 1ns/1ps

module wb_decoder (
  input  logic     sys_clk,
  input  logic     rst_n_i,
  wb_bus_if.slave  wbm,
  wb_bus_if.master wbs0
);

  logic [spi_wb_pkg::n_slaves_c-1:0] hit;
  logic                              miss;
  logic                              err_q;

  // offset compare covers base and high inclusive.
  always_comb begin
    for (int i = 0; i < spi_wb_pkg::n_slaves_c; i++) begin
      hit[i] = (wbm.adr - spi_wb_pkg::slave_base_c[i]) <=
               (spi_wb_pkg::slave_high_c[i] - spi_wb_pkg::slave_base_c[i]);
    end
  end

  assign miss = ~|hit;

  assign wbs0.cyc   = wbm.cyc & hit[spi_wb_pkg::sysblock_id_c];
  assign wbs0.stb   = wbm.stb & hit[spi_wb_pkg::sysblock_id_c];
  assign wbs0.we    = wbm.we;
  assign wbs0.sel   = wbm.sel;
  assign wbs0.adr   = wbm.adr;
  assign wbs0.dat_w = wbm.dat_w;

  assign wbm.dat_r = hit[spi_wb_pkg::sysblock_id_c] ? wbs0.dat_r : '0;
  assign wbm.ack   = wbs0.ack;
  assign wbm.err   = wbs0.err | err_q;

  // unmapped access gets a single err pulse.
  always_ff @(posedge sys_clk) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= wbm.cyc & wbm.stb & miss & ~err_q;
    end
  end

endmodule

// ==== design/sys_block.sv ====
`timescale 1ns/1ps

module sys_block (
  input  logic    sys_clk,
  input  logic    rst_n_i,
  wb_bus_if.slave wb
);

  spi_wb_pkg::reg_off_t off;
  spi_wb_pkg::wb_data_t scratch_q;
  spi_wb_pkg::wb_data_t rd_q;
  logic                 ack_q;
  logic                 access;

  assign off    = wb.adr[3:2];
  assign access = wb.cyc & wb.stb & ~ack_q;  // one ack per request.

  always_ff @(posedge sys_clk) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
    end else begin
      ack_q <= access;
      if (access && wb.we && off == spi_wb_pkg::reg_scratch_c) begin
        for (int b = 0; b < 4; b++) begin
          if (wb.sel[b]) scratch_q[8*b +: 8] <= wb.dat_w[8*b +: 8];
        end
      end
    end
  end

  // read mux for all four offsets.
  always_ff @(posedge sys_clk) begin
    if (access) begin
      case (off)
        spi_wb_pkg::reg_id_c:  rd_q <= spi_wb_pkg::board_id_c;
        spi_wb_pkg::reg_rev_c: rd_q <= {spi_wb_pkg::rev_maj_c, spi_wb_pkg::rev_min_c};
        spi_wb_pkg::reg_rcs_c: rd_q <= spi_wb_pkg::rev_rcs_c;
        default:               rd_q <= scratch_q;
      endcase
    end
  end

  assign wb.dat_r = rd_q;
  assign wb.ack   = ack_q;
  assign wb.err   = 1'b0;  // every offset is valid.

endmodule

// ==== design/spi_wb_top.sv ====
`timescale 1ns/1ps

module spi_wb_top (
  input  logic sys_clk,
  input  logic rst_n_i,
  input  logic cs_n_i,
  input  logic sclk_i,
  input  logic mosi_i,
  output logic miso_o,
  output logic cmd_done_o
);

  wb_bus_if wb_m ();   // bridge to decoder.
  wb_bus_if wb_s0 ();  // decoder to sys_block.

  spi_wb_bridge spi_wb_bridge_inst (
    .sys_clk    (sys_clk),
    .rst_n_i    (rst_n_i),
    .cs_n_i     (cs_n_i),
    .sclk_i     (sclk_i),
    .mosi_i     (mosi_i),
    .miso_o     (miso_o),
    .cmd_done_o (cmd_done_o),
    .wb         (wb_m)
  );

  wb_decoder wb_decoder_inst (
    .sys_clk (sys_clk),
    .rst_n_i (rst_n_i),
    .wbm     (wb_m),
    .wbs0    (wb_s0)
  );

  sys_block sys_block_inst (
    .sys_clk (sys_clk),
    .rst_n_i (rst_n_i),
    .wb      (wb_s0)
  );

endmodule

// ==== test/tb_spi_wb_top.sv ====
`timescale 1ns/1ps

module tb_spi_wb_top;

  localparam int half_c         = 4;    // sys_clk cycles per sclk half period.
  localparam int gap_c          = 8;
  localparam int max_vec_c      = 64;
  localparam int done_timeout_c = 400;
  localparam string golden_file_c = "test/golden_spi_vectors.txt";

  localparam spi_wb_pkg::wb_data_t op_read_c  = 32'h0;
  localparam spi_wb_pkg::wb_data_t op_write_c = 32'h1;
  localparam spi_wb_pkg::wb_data_t op_abort_c = 32'h2;
  localparam spi_wb_pkg::wb_data_t op_end_c   = 32'hF;

  localparam spi_wb_pkg::spi_cmd_t cmd_read_c  = 8'h03;  // low bits are don't care.
  localparam spi_wb_pkg::spi_cmd_t cmd_write_c = 8'h82;

  logic sys_clk = 1'b0;
  logic rst_n_i;
  logic cs_n_i;
  logic sclk_i;
  logic mosi_i;
  logic miso_o;
  logic cmd_done_o;

  spi_wb_pkg::wb_data_t vec_mem [0:4*max_vec_c-1];
  int done_cnt = 0;
  int errors   = 0;
  int checks   = 0;
  int tests    = 0;

  spi_wb_top dut (
    .sys_clk    (sys_clk),
    .rst_n_i    (rst_n_i),
    .cs_n_i     (cs_n_i),
    .sclk_i     (sclk_i),
    .mosi_i     (mosi_i),
    .miso_o     (miso_o),
    .cmd_done_o (cmd_done_o)
  );

  always #50 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    if (rst_n_i && cmd_done_o) done_cnt++;
  end

  // lands 1 ns after the edge.
  task automatic wait_clks(input int n);
    repeat (n) @(posedge sys_clk);
    #1;
  endtask

  task automatic spi_bit(input logic mosi_bit, output logic miso_bit);
    mosi_i = mosi_bit;
    sclk_i = 1'b0;
    wait_clks(half_c);
    miso_bit = miso_o;  // sampled at the rising edge.
    sclk_i = 1'b1;
    wait_clks(half_c);
  endtask

  task automatic spi_frame(input spi_wb_pkg::spi_cmd_t cmd, input spi_wb_pkg::wb_addr_t addr,
                           input spi_wb_pkg::wb_data_t wdata, input int addr_bits,
                           output spi_wb_pkg::wb_data_t rdata);
    logic s;
    int   i;
    rdata  = '0;
    cs_n_i = 1'b0;
    wait_clks(half_c);
    for (i = 7; i >= 0; i--) spi_bit(cmd[i], s);
    for (i = 31; i >= 32 - addr_bits; i--) spi_bit(addr[i], s);
    if (addr_bits == 32 && cmd[7]) begin
      for (i = 31; i >= 0; i--) spi_bit(wdata[i], s);
    end else if (addr_bits == 32) begin
      for (i = 0; i < 8; i++) spi_bit(1'b0, s);  // dummy byte.
      for (i = 0; i < 32; i++) begin
        spi_bit(1'b0, s);
        rdata = {rdata[30:0], s};
      end
    end
    sclk_i = 1'b0;
    mosi_i = 1'b0;
    wait_clks(half_c);
    cs_n_i = 1'b1;
    wait_clks(gap_c);
  endtask

  task automatic wait_done(input int target, input int test_no, output logic timed_out);
    int n;
    n = 0;
    timed_out = 1'b0;
    while (done_cnt < target && n < done_timeout_c) begin
      wait_clks(1);
      n++;
    end
    if (done_cnt < target) begin
      $display("test %0d: cmd_done_o never pulsed, timed out waiting", test_no);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_data(input spi_wb_pkg::wb_data_t exp, input spi_wb_pkg::wb_data_t got);
    checks++;
    if (got !== exp) begin
      $display("Fail miso_o exp 0x%08h got 0x%08h", exp, got);
      errors++;
    end
  endtask

  task automatic check_count(input int exp, input int got);
    checks++;
    if (got != exp) begin
      $display("Fail cmd_done_o count exp 0x%0h got 0x%0h", exp, got);
      errors++;
    end
  endtask

  initial begin : main
    spi_wb_pkg::wb_data_t op;
    spi_wb_pkg::wb_addr_t addr;
    spi_wb_pkg::wb_data_t wdata;
    spi_wb_pkg::wb_data_t exp;
    spi_wb_pkg::wb_data_t rdata;
    int   t;
    int   exp_done;
    int   err_before;
    logic timed_out;
    rst_n_i = 1'b0;
    cs_n_i  = 1'b1;
    sclk_i  = 1'b0;
    mosi_i  = 1'b0;
    $readmemh(golden_file_c, vec_mem);
    wait_clks(8);
    rst_n_i = 1'b1;
    wait_clks(gap_c);
    t = 0;
    exp_done = 0;
    timed_out = 1'b0;
    while (t < max_vec_c && vec_mem[4*t] != op_end_c && !timed_out) begin
      op     = vec_mem[4*t];
      addr   = vec_mem[4*t+1];
      wdata  = vec_mem[4*t+2];
      exp    = vec_mem[4*t+3];
      if (op != op_abort_c) exp_done++;  // aborted frame gives no pulse.
      err_before = errors;
      if (op == op_read_c) spi_frame(cmd_read_c, addr, wdata, 32, rdata);
      else if (op == op_write_c) spi_frame(cmd_write_c, addr, wdata, 32, rdata);
      else spi_frame(cmd_write_c, addr, wdata, 16, rdata);
      wait_done(exp_done, t, timed_out);
      if (!timed_out) begin
        wait_clks(half_c);
        check_count(exp_done, done_cnt);
        if (op == op_read_c) check_data(exp, rdata);
        tests++;
        $display("test %0d op %0h addr 0x%08h %s", t, op, addr,
                 (errors == err_before) ? "ok" : "wrong");
      end
      t++;
    end
    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out && tests > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== test/golden_spi_vectors.txt ====
// columns: op address write_data expected_read (hex)
// op 0 read, 1 write, 2 write aborted mid-address, f end of list
0 00000000 00000000 0000000C
0 00000004 00000000 00010000
0 00000008 00000000 00000000
0 0000000C 00000000 00000000
1 0000000C A5A55A5A 00000000
0 0000000C 00000000 A5A55A5A
1 0000000C 12345678 00000000
0 0000000C 00000000 12345678
1 0000000C FFFFFFFF 00000000
0 0000000C 00000000 FFFFFFFF
1 00000000 DEADBEEF 00000000 // id is read only
0 00000000 00000000 0000000C
1 00000004 CAFEF00D 00000000
0 00000004 00000000 00010000
2 0000000C 0BADCAFE 00000000
0 0000000C 00000000 FFFFFFFF
0 00010000 00000000 BAD0E770
0 FFFFFFFC 00000000 BAD0E770
f 00000000 00000000 00000000

// ==== flist.f ====
design/spi_wb_pkg.sv
design/wb_bus_if.sv
design/spi_wb_bridge.sv
design/wb_decoder.sv
design/sys_block.sv
design/spi_wb_top.sv
test/tb_spi_wb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spi_wb_top
RTL_TOP   ?= spi_wb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
